//--- Bender.yml
package:
  name: mips_datapath

sources:
  - include_dirs:
      - source
    files:
      - source/mipsPkg.sv
      - source/registerFile.sv
      - source/decodeStage.sv
      - source/executeStage.sv
      - source/resultStage.sv
      - source/datapath.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/datapathTb.sv

//--- dv/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module datapathTb;
	import mipsPkg::*;

	localparam int resetCycles = 10;
	localparam int imemWords = 64;
	localparam int dmemWords = 256;

	logic        clk = 1'b0;
	logic        rstN;
	logic [31:0] instr;
	logic [31:0] readData;
	logic [31:0] pc;
	logic [31:0] fetchOffset;
	dataReq_t    dataReq;
	retire_t     retire;

	logic [31:0] instrMem [imemWords];
	logic [31:0] dataMem [dmemWords];
	retire_t     expRetire [$];
	dataReq_t    expStore [$];
	int          progLen = 0;
	int          retireIdx = 0;
	int          storeIdx = 0;
	logic        patternsLoaded = 1'b0;

	always #4 clk = ~clk;

	datapath dut (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.readData(readData),
		.pc(pc),
		.dataReq(dataReq),
		.retire(retire)
	);

	//////////////////////////////
	// memory models
	//////////////////////////////

	// program sits at the boot vector, nop outside it
	assign fetchOffset = pc - `DP_RESET_PC;
	assign instr = (fetchOffset[31:2] < imemWords) ? instrMem[fetchOffset[31:2]] : 32'h0;

	// word addressed, answers in the same cycle
	assign readData = dataMem[dataReq.addr[9:2]];

	always @(posedge clk) begin
		if (dataReq.write) begin
			for (int b = 0; b < 4; b++) begin
				if (dataReq.byteEnable[b]) begin
					dataMem[dataReq.addr[9:2]][8*b +: 8] <= dataReq.wdata[8*b +: 8];
				end
			end
		end
	end

	//////////////////////////////
	// checking
	//////////////////////////////

	task automatic failNow();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic reportMismatch(input string field, input logic [31:0] got,
		input logic [31:0] exp);
		$display("mismatch at %0t: %s got %h, expected %h", $time, field, got, exp);
		failNow();
	endtask

	task automatic checkRetire(input retire_t got, input retire_t exp);
		if (got.pc !== exp.pc) begin
			reportMismatch("retire pc", got.pc, exp.pc);
		end
		if (got.wnum !== exp.wnum) begin
			reportMismatch("retire wnum", {27'b0, got.wnum}, {27'b0, exp.wnum});
		end
		if (got.wdata !== exp.wdata) begin
			reportMismatch("retire wdata", got.wdata, exp.wdata);
		end
	endtask

	task automatic checkStore(input dataReq_t got, input dataReq_t exp);
		if (got.addr !== exp.addr) begin
			reportMismatch("store addr", got.addr, exp.addr);
		end
		if (got.byteEnable !== exp.byteEnable) begin
			reportMismatch("store byteEnable", {28'b0, got.byteEnable}, {28'b0, exp.byteEnable});
		end
		if (got.wdata !== exp.wdata) begin
			reportMismatch("store wdata", got.wdata, exp.wdata);
		end
	endtask

	// one record per line, tag letter first, # starts a comment
	task automatic loadPatterns();
		int                fd;
		int                code;
		logic [7:0]        tag;
		logic [31:0]       a, b, c;
		logic [8*128-1:0]  line;
		retire_t           r;
		dataReq_t          s;
		for (int i = 0; i < imemWords; i++) begin
			instrMem[i] = 32'h0;
		end
		// fill tracks the byte address, so lanes untouched by sb stay visible
		for (int i = 0; i < dmemWords; i++) begin
			dataMem[i] = 32'h5A5A0000 ^ (i * 4);
		end
		fd = $fopen("dv/datapath_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/datapath_patterns.txt");
			failNow();
		end
		while ($fscanf(fd, " %c", tag) == 1) begin
			case (tag)
				"I": begin
					code = $fscanf(fd, "%h", a);
					if (code != 1 || progLen >= imemWords) begin
						$display("bad or excess program word in the pattern file");
						failNow();
					end else begin
						instrMem[progLen] = a;
						progLen++;
					end
				end
				"R": begin
					code = $fscanf(fd, "%h %h %h", a, b, c);
					if (code != 3) begin
						$display("retire record in the pattern file is incomplete");
						failNow();
					end else begin
						r.pc = a;
						r.wen = 1'b1;
						r.wnum = b[4:0];
						r.wdata = c;
						expRetire.push_back(r);
					end
				end
				"S": begin
					code = $fscanf(fd, "%h %h %h", a, b, c);
					if (code != 3) begin
						$display("store record in the pattern file is incomplete");
						failNow();
					end else begin
						s.addr = a;
						s.wdata = c;
						s.byteEnable = b[3:0];
						s.write = 1'b1;
						expStore.push_back(s);
					end
				end
				"#": code = $fgets(line, fd);
				default: begin
					$display("unknown record tag %c in the pattern file", tag);
					failNow();
				end
			endcase
		end
		$fclose(fd);
		patternsLoaded = 1'b1;
	endtask

	// outputs are stable mid cycle
	always @(negedge clk) begin
		if (retire.wen) begin
			if (retireIdx >= expRetire.size()) begin
				$display("retire of pc %h came after the expected trace ended", retire.pc);
				failNow();
			end else begin
				checkRetire(retire, expRetire[retireIdx]);
				retireIdx++;
			end
		end
		if (dataReq.write) begin
			if (retireIdx == 0) begin
				$display("store to %h appeared before the first retire", dataReq.addr);
				failNow();
			end else if (storeIdx >= expStore.size()) begin
				$display("store to %h came after the expected trace ended", dataReq.addr);
				failNow();
			end else begin
				checkStore(dataReq, expStore[storeIdx]);
				storeIdx++;
			end
		end
	end

	//////////////////////////////
	// run control
	//////////////////////////////

	initial begin
		rstN <= 1'b0;
		loadPatterns();
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		wait (retireIdx == expRetire.size() && storeIdx == expStore.size());
		// a few idle cycles to catch stray events
		repeat (8) @(posedge clk);
		$display("ALL TESTS PASSED");
		$finish;
	end

	// bound scales with the program, three cycles per word is plenty
	initial begin
		wait (patternsLoaded);
		repeat (resetCycles + (progLen + 20) * 3) @(posedge clk);
		$display("timed out with %0d of %0d retires seen", retireIdx, expRetire.size());
		failNow();
	end

endmodule

`default_nettype wire

//--- dv/datapath_patterns.txt
# I word | R pc wnum wdata | S addr byteEnable wdata, all hex
# I words load upward from the reset pc, # starts a comment
I 3C011234 # lui   $1, 0x1234
I 34215678 # ori   $1, $1, 0x5678
I 24020100 # addiu $2, $0, 0x100
I AC410000 # sw    $1, 0($2)
I A0410005 # sb    $1, 5($2)
I 8C430000 # lw    $3, 0($2)
I 00622021 # addu  $4, $3, $2
I 00812823 # subu  $5, $4, $1
I 10A20002 # beq   $5, $2, +2 taken
I 0044302A # slt   $6, $2, $4 delay slot
I 24077777 # addiu $7, $0, 0x7777 skipped
I 00013900 # sll   $7, $1, 4
I 14E70002 # bne   $7, $7, +2 not taken
I 00E34025 # or    $8, $7, $3 delay slot
I 0BF00011 # j     0xBFC00044
I 00220019 # multu $1, $2 delay slot
I 24090BAD # addiu $9, $0, 0xBAD skipped
I 00005010 # mfhi  $10
I 00005812 # mflo  $11
I A04A0007 # sb    $10, 7($2)
I 8C4C0004 # lw    $12, 4($2)
# retire trace
R BFC00000 01 12340000
R BFC00004 01 12345678
R BFC00008 02 00000100
R BFC00014 03 12345678
R BFC00018 04 12345778
R BFC0001C 05 00000100
R BFC00024 06 00000001
R BFC0002C 07 23456780
R BFC00034 08 337577F8
R BFC00044 0A 00000012
R BFC00048 0B 34567800
R BFC00050 0C 125A7804
# store trace
S 00000100 F 12345678
S 00000105 2 78787878
S 00000107 8 12121212

//--- filelist.f
+incdir+source
source/mipsPkg.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/datapath.sv
dv/datapathTb.sv

//--- source/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module datapath (
	input  logic              clk,
	input  logic              rstN,
	input  logic [31:0]       instr,
	input  logic [31:0]       readData,
	output logic [31:0]       pc,
	output mipsPkg::dataReq_t dataReq,
	output mipsPkg::retire_t  retire
);
	import mipsPkg::*;

	// register file read side
	logic [$clog2(`DP_REG_COUNT)-1:0] raddrA, raddrB;
	logic [31:0]                      rdataA, rdataB;

	// forward path between stages
	decExec_t                  toExec;
	logic                      flushE;
	execMem_t                  toMem;

	// backward path, hazards and bypass
	execHaz_t                  execHaz;
	memFwd_t                   memFwd;
	wbFwd_t                    wbFwd;
	logic [`DP_PROD_WIDTH-1:0] hiLo;

	//////////////////////////////
	// stages
	//////////////////////////////

	decodeStage decode (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.rdataA(rdataA),
		.rdataB(rdataB),
		.memFwd(memFwd),
		.execHaz(execHaz),
		.pc(pc),
		.raddrA(raddrA),
		.raddrB(raddrB),
		.toExec(toExec),
		.flushE(flushE)
	);

	executeStage execute (
		.clk(clk),
		.rstN(rstN),
		.fromDec(toExec),
		.flushE(flushE),
		.memFwd(memFwd),
		.wbFwd(wbFwd),
		.hiLo(hiLo),
		.toMem(toMem),
		.execHaz(execHaz)
	);

	resultStage result (
		.clk(clk),
		.rstN(rstN),
		.fromExec(toMem),
		.readData(readData),
		.dataReq(dataReq),
		.memFwd(memFwd),
		.wbFwd(wbFwd),
		.hiLo(hiLo),
		.retire(retire)
	);

	// written from writeback, read in decode
	registerFile rf (
		.clk(clk),
		.rstN(rstN),
		.raddrA(raddrA),
		.raddrB(raddrB),
		.waddr(wbFwd.writeReg),
		.wen(wbFwd.regWrite),
		.wdata(wbFwd.result),
		.rdataA(rdataA),
		.rdataB(rdataB)
	);

endmodule

`default_nettype wire

//--- source/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module decodeStage (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [31:0]                      instr,
	input  logic [31:0]                      rdataA,
	input  logic [31:0]                      rdataB,
	input  mipsPkg::memFwd_t                 memFwd,
	input  mipsPkg::execHaz_t                execHaz,
	output logic [31:0]                      pc,
	output logic [$clog2(`DP_REG_COUNT)-1:0] raddrA,
	output logic [$clog2(`DP_REG_COUNT)-1:0] raddrB,
	output mipsPkg::decExec_t                toExec,
	output logic                             flushE
);
	import mipsPkg::*;

	// primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSb = 6'h28;
	localparam logic [5:0] opSw = 6'h2b;
	// special function codes
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnMfhi = 6'h10;
	localparam logic [5:0] fnMflo = 6'h12;
	localparam logic [5:0] fnMultu = 6'h19;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	instrWord_u  instrD;
	logic [31:0] pcD;
	ctrl_t       ctrlD;
	logic [4:0]  writeRegD;
	logic        isBeq, isBne, isJump, usesRs, usesRt;
	logic [31:0] immD, cmpA, cmpB, pcPlus4D, branchTarget, jumpTarget, nextPc;
	logic        branchTaken, exMatch, memLoadMatch, loadUse, branchStall, stall;

	//////////////////////////////
	// fetch
	//////////////////////////////

	// pc and F/D both freeze on a stall
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `DP_RESET_PC;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrD <= '0;
			pcD <= '0;
		end else if (!stall) begin
			instrD <= instr;
			pcD <= pc;
		end
	end

	// delay slot already fetched, so the redirect goes straight into pc
	assign pcPlus4D = pcD + 32'd4;
	assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTarget = {pcPlus4D[31:28], instrD[25:0], 2'b00};
	assign nextPc = isJump ? jumpTarget : (branchTaken ? branchTarget : pc + 32'd4);

	//////////////////////////////
	// control decode
	//////////////////////////////

	always_comb begin
		ctrlD = '0;
		isBeq = 1'b0;
		isBne = 1'b0;
		isJump = 1'b0;
		unique case (instrD.i.op)
			opSpecial: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.regDstRd = 1'b1;
				unique case (instrD.r.funct)
					fnAddu: ctrlD.aluOp = aluAdd;
					fnSubu: ctrlD.aluOp = aluSub;
					fnAnd: ctrlD.aluOp = aluAnd;
					fnOr: ctrlD.aluOp = aluOr;
					fnSlt: ctrlD.aluOp = aluSlt;
					fnSll: ctrlD.aluOp = aluSll;
					fnMultu: begin
						ctrlD.regWrite = 1'b0;
						ctrlD.hiloWrite = 1'b1;
					end
					fnMfhi: begin
						ctrlD.wbSel = wbHi;
						ctrlD.aluOp = aluPassA;
					end
					fnMflo: begin
						ctrlD.wbSel = wbLo;
						ctrlD.aluOp = aluPassA;
					end
					default: ctrlD.regWrite = 1'b0;
				endcase
			end
			opAddiu: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrcImm = 1'b1;
			end
			opOri: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.zeroExtImm = 1'b1;
				ctrlD.aluOp = aluOr;
			end
			opLui: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.zeroExtImm = 1'b1;
				ctrlD.aluOp = aluLui;
			end
			opLw: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.memRead = 1'b1;
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.wbSel = wbMem;
			end
			opSw, opSb: begin
				ctrlD.memWrite = 1'b1;
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.byteStore = (instrD.i.op == opSb);
			end
			opBeq: isBeq = 1'b1;
			opBne: isBne = 1'b1;
			opJ: isJump = 1'b1;
			default: ctrlD = '0;
		endcase
		writeRegD = ctrlD.regDstRd ? instrD.r.rd : instrD.i.rt;
		// a write to r0 does nothing, so it becomes a bubble
		if (ctrlD.regWrite && writeRegD == '0) begin
			ctrlD = '0;
		end
	end

	assign immD = ctrlD.zeroExtImm ? {16'b0, instrD.i.imm16} :
		{{16{instrD.i.imm16[15]}}, instrD.i.imm16};

	// rt is a source for register ops, branches and stores
	assign usesRs = !isJump;
	assign usesRt = (instrD.i.op == opSpecial) || isBeq || isBne || ctrlD.memWrite;

	//////////////////////////////
	// branch compare and hazards
	//////////////////////////////

	// mem stage bypass, writeback comes through the register file
	assign cmpA = (memFwd.regWrite && !memFwd.memRead && memFwd.writeReg == instrD.r.rs) ?
		memFwd.aluOut : rdataA;
	assign cmpB = (memFwd.regWrite && !memFwd.memRead && memFwd.writeReg == instrD.r.rt) ?
		memFwd.aluOut : rdataB;
	assign branchTaken = (isBeq && cmpA == cmpB) || (isBne && cmpA != cmpB);

	assign exMatch = execHaz.regWrite &&
		((usesRs && execHaz.writeReg == instrD.r.rs) ||
		(usesRt && execHaz.writeReg == instrD.r.rt));
	assign memLoadMatch = memFwd.memRead && memFwd.regWrite &&
		((usesRs && memFwd.writeReg == instrD.r.rs) ||
		(usesRt && memFwd.writeReg == instrD.r.rt));

	// load in execute feeding anything
	assign loadUse = execHaz.memRead && exMatch;
	// branch waits until its operand can come from mem
	assign branchStall = (isBeq || isBne) && (exMatch || memLoadMatch);
	assign stall = loadUse || branchStall;
	assign flushE = stall;

	assign raddrA = instrD.r.rs;
	assign raddrB = instrD.r.rt;

	assign toExec = '{
		ctrl: ctrlD,
		pc: pcD,
		srcA: rdataA,
		srcB: rdataB,
		imm: immD,
		shamt: instrD.r.shamt,
		rs: instrD.r.rs,
		rt: instrD.r.rt,
		writeReg: writeRegD
	};

endmodule

`default_nettype wire

//--- source/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module executeStage (
	input  logic                      clk,
	input  logic                      rstN,
	input  mipsPkg::decExec_t         fromDec,
	input  logic                      flushE,
	input  mipsPkg::memFwd_t          memFwd,
	input  mipsPkg::wbFwd_t           wbFwd,
	input  logic [`DP_PROD_WIDTH-1:0] hiLo,
	output mipsPkg::execMem_t         toMem,
	output mipsPkg::execHaz_t         execHaz
);
	import mipsPkg::*;

	decExec_t                  execStage;
	logic [31:0]               fwdA, fwdB, aluA, aluB, aluOut, storeData;
	logic [3:0]                byteEnable;
	logic [`DP_PROD_WIDTH-1:0] product;

	// D/E register
	// decode stall drops a bubble in here
	always_ff @(posedge clk) begin
		if (!rstN || flushE) begin
			execStage <= '0;
		end else begin
			execStage <= fromDec;
		end
	end

	//////////////////////////////
	// operand bypass
	//////////////////////////////

	// newest producer first, mem over writeback
	function automatic logic [31:0] forwardOperand(
		input logic [4:0]  src,
		input logic [31:0] regVal,
		input memFwd_t     memSide,
		input wbFwd_t      wbSide
	);
		if (memSide.regWrite && !memSide.memRead && memSide.writeReg == src) begin
			return memSide.aluOut;
		end
		if (wbSide.regWrite && wbSide.writeReg == src) begin
			return wbSide.result;
		end
		return regVal;
	endfunction

	assign fwdA = forwardOperand(execStage.rs, execStage.srcA, memFwd, wbFwd);
	assign fwdB = forwardOperand(execStage.rt, execStage.srcB, memFwd, wbFwd);

	// mfhi and mflo pass hi or lo through port A
	always_comb begin
		unique case (execStage.ctrl.wbSel)
			wbHi: aluA = hiLo[`DP_PROD_WIDTH-1 -: 32];
			wbLo: aluA = hiLo[31:0];
			default: aluA = fwdA;
		endcase
	end

	assign aluB = execStage.ctrl.aluSrcImm ? execStage.imm : fwdB;

	//////////////////////////////
	// alu and multiplier
	//////////////////////////////

	always_comb begin
		unique case (execStage.ctrl.aluOp)
			aluAdd: aluOut = aluA + aluB;
			aluSub: aluOut = aluA - aluB;
			aluAnd: aluOut = aluA & aluB;
			aluOr: aluOut = aluA | aluB;
			aluSlt: aluOut = {31'b0, $signed(aluA) < $signed(aluB)};
			// shift amount from the instruction, value from rt
			aluSll: aluOut = aluB << execStage.shamt;
			aluLui: aluOut = {aluB[15:0], 16'b0};
			aluPassA: aluOut = aluA;
			default: aluOut = '0;
		endcase
	end

	// unsigned only, multu
	assign product = `DP_PROD_WIDTH'(fwdA) * `DP_PROD_WIDTH'(fwdB);

	// store lanes, little endian
	always_comb begin
		if (execStage.ctrl.byteStore) begin
			storeData = {4{fwdB[7:0]}};
			byteEnable = 4'b0001 << aluOut[1:0];
		end else begin
			storeData = fwdB;
			byteEnable = execStage.ctrl.memWrite ? 4'b1111 : 4'b0000;
		end
	end

	assign toMem = '{
		ctrl: execStage.ctrl,
		pc: execStage.pc,
		aluOut: aluOut,
		storeData: storeData,
		byteEnable: byteEnable,
		product: product,
		writeReg: execStage.writeReg
	};

	// seen by decode for load-use and branch stalls
	assign execHaz = '{
		writeReg: execStage.writeReg,
		regWrite: execStage.ctrl.regWrite,
		memRead: execStage.ctrl.memRead
	};

endmodule

`default_nettype wire

//--- source/mipsPkg.sv
`default_nettype none

`include "mips_params.svh"

package mipsPkg;

	//////////////////////////////
	// instruction word
	//////////////////////////////

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFields_t;

	// same 32 bits, register or immediate layout
	typedef union packed {
		rFields_t r;
		iFields_t i;
	} instrWord_u;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSll,
		aluLui,
		aluPassA
	} aluOp_e;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbHi,
		wbLo
	} wbSel_e;

	// all zero is a bubble
	typedef struct packed {
		logic   regWrite;
		logic   memWrite;
		logic   memRead;
		logic   byteStore;
		logic   aluSrcImm;
		logic   zeroExtImm;
		logic   regDstRd;
		logic   hiloWrite;
		wbSel_e wbSel;
		aluOp_e aluOp;
	} ctrl_t;

	//////////////////////////////
	// stage registers
	//////////////////////////////

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] pc;
		logic [31:0] srcA;
		logic [31:0] srcB;
		logic [31:0] imm;
		logic [4:0]  shamt;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  writeReg;
	} decExec_t;

	typedef struct packed {
		ctrl_t                     ctrl;
		logic [31:0]               pc;
		logic [31:0]               aluOut;
		logic [31:0]               storeData;
		logic [3:0]                byteEnable;
		logic [`DP_PROD_WIDTH-1:0] product;
		logic [4:0]                writeReg;
	} execMem_t;

	typedef struct packed {
		logic        regWrite;
		wbSel_e      wbSel;
		logic [31:0] pc;
		logic [31:0] aluOut;
		logic [31:0] readData;
		logic [4:0]  writeReg;
	} memWb_t;

	// hazard and bypass views of the later stages
	typedef struct packed {
		logic [31:0] aluOut;
		logic [4:0]  writeReg;
		logic        regWrite;
		logic        memRead;
	} memFwd_t;

	typedef struct packed {
		logic [31:0] result;
		logic [4:0]  writeReg;
		logic        regWrite;
	} wbFwd_t;

	typedef struct packed {
		logic [4:0] writeReg;
		logic       regWrite;
		logic       memRead;
	} execHaz_t;

	//////////////////////////////
	// external ports
	//////////////////////////////

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  byteEnable;
		logic        write;
	} dataReq_t;

	typedef struct packed {
		logic [31:0] pc;
		logic        wen;
		logic [4:0]  wnum;
		logic [31:0] wdata;
	} retire_t;

endpackage

`default_nettype wire

//--- source/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// boot vector, first fetch address out of reset
`define DP_RESET_PC 32'hBFC00000

// general purpose registers, r0 included
`define DP_REG_COUNT 32

// full multu result
// upper half lands in hi, lower half in lo
`define DP_PROD_WIDTH 64

`endif

//--- source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module registerFile (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [$clog2(`DP_REG_COUNT)-1:0] raddrA,
	input  logic [$clog2(`DP_REG_COUNT)-1:0] raddrB,
	input  logic [$clog2(`DP_REG_COUNT)-1:0] waddr,
	input  logic                             wen,
	input  logic [31:0]                      wdata,
	output logic [31:0]                      rdataA,
	output logic [31:0]                      rdataB
);

	logic [31:0] regs [`DP_REG_COUNT];

	// writeback port, held off while in reset
	always_ff @(posedge clk) begin
		if (rstN && wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 reads zero, same-cycle write goes straight through
	assign rdataA = (raddrA == '0) ? '0 :
		((wen && waddr == raddrA) ? wdata : regs[raddrA]);
	assign rdataB = (raddrB == '0) ? '0 :
		((wen && waddr == raddrB) ? wdata : regs[raddrB]);

endmodule

`default_nettype wire

//--- source/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module resultStage (
	input  logic                      clk,
	input  logic                      rstN,
	input  mipsPkg::execMem_t         fromExec,
	input  logic [31:0]               readData,
	output mipsPkg::dataReq_t         dataReq,
	output mipsPkg::memFwd_t          memFwd,
	output mipsPkg::wbFwd_t           wbFwd,
	output logic [`DP_PROD_WIDTH-1:0] hiLo,
	output mipsPkg::retire_t          retire
);
	import mipsPkg::*;

	execMem_t                  memStage;
	memWb_t                    wbStage;
	logic [`DP_PROD_WIDTH-1:0] hiLoReg;
	logic [31:0]               result;

	//////////////////////////////
	// memory stage
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memStage <= '0;
		end else begin
			memStage <= fromExec;
		end
	end

	// data port, memory answers in the same cycle
	assign dataReq = '{
		addr: memStage.aluOut,
		wdata: memStage.storeData,
		byteEnable: memStage.byteEnable,
		write: memStage.ctrl.memWrite
	};

	// hi/lo written at the end of mem
	always_ff @(posedge clk) begin
		if (!rstN) begin
			hiLoReg <= '0;
		end else if (memStage.ctrl.hiloWrite) begin
			hiLoReg <= memStage.product;
		end
	end

	// multu still in mem bypasses to an mfhi/mflo in execute
	assign hiLo = memStage.ctrl.hiloWrite ? memStage.product : hiLoReg;

	assign memFwd = '{
		aluOut: memStage.aluOut,
		writeReg: memStage.writeReg,
		regWrite: memStage.ctrl.regWrite,
		memRead: memStage.ctrl.memRead
	};

	//////////////////////////////
	// writeback stage
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbStage <= '0;
		end else begin
			wbStage <= '{
				regWrite: memStage.ctrl.regWrite,
				wbSel: memStage.ctrl.wbSel,
				pc: memStage.pc,
				aluOut: memStage.aluOut,
				readData: readData,
				writeReg: memStage.writeReg
			};
		end
	end

	// hi and lo values already ride in aluOut
	assign result = (wbStage.wbSel == wbMem) ? wbStage.readData : wbStage.aluOut;

	assign wbFwd = '{
		result: result,
		writeReg: wbStage.writeReg,
		regWrite: wbStage.regWrite
	};

	assign retire = '{
		pc: wbStage.pc,
		wen: wbStage.regWrite,
		wnum: wbStage.writeReg,
		wdata: result
	};

endmodule

`default_nettype wire
